// ==== src/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    // Frame format, 8N1
    localparam int DATA_BITS = 8;
    localparam int SB_TICK   = 16;   // Oversampling ticks in the stop bit

    // Baud generator
    // 4 clocks per tick and 16 ticks per bit, so a bit is 64 clocks
    localparam int TICK_DIV = 4;

    // Byte FIFOs on both serial directions
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = 2;   // log2 of FIFO_DEPTH

    // FIFO status seen by the consumer side
    typedef struct packed {
        logic empty;   // Nothing to read
        logic full;    // Writes are dropped
    } fifo_stat_t;

endpackage

`default_nettype wire

// ==== src/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    localparam int OPCODE_BITS = 6;

    // MIPS-style function codes
    localparam logic [OPCODE_BITS-1:0] OP_ADD = 6'h20;
    localparam logic [OPCODE_BITS-1:0] OP_SUB = 6'h22;
    localparam logic [OPCODE_BITS-1:0] OP_AND = 6'h24;
    localparam logic [OPCODE_BITS-1:0] OP_OR  = 6'h25;
    localparam logic [OPCODE_BITS-1:0] OP_XOR = 6'h26;
    localparam logic [OPCODE_BITS-1:0] OP_NOR = 6'h27;
    localparam logic [OPCODE_BITS-1:0] OP_SRA = 6'h03;   // A >>> B[2:0]
    localparam logic [OPCODE_BITS-1:0] OP_SRL = 6'h02;   // A >> B[2:0]

    // Decoded layout of the instruction word, LSB byte is operand A
    typedef struct packed {
        logic [7:0]             pad;      // Always zero
        logic [1:0]             rsv;      // Upper bits of the opcode byte, cleared
        logic [OPCODE_BITS-1:0] opcode;
        logic [7:0]             op_b;
        logic [7:0]             op_a;
    } inst_fields_t;

    // Same 32 bits seen as the bytes received over the serial line
    typedef union packed {
        logic [3:0][7:0] bytes;    // Byte index = arrival order
        inst_fields_t    fields;
    } inst_word_u;

endpackage

`default_nettype wire

// ==== src/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx
    import uart_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire                  i_tick,   // 16x baud strobe
    input  wire                  i_rx,
    output logic [DATA_BITS-1:0] o_data,
    output logic                 o_done    // One cycle, data valid
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef logic [$clog2(DATA_BITS)-1:0] bit_cnt_t;

    rx_state_t            state;
    logic [3:0]           tick_cnt;   // Ticks inside the current bit
    bit_cnt_t             bit_cnt;    // Data bits taken so far
    logic [DATA_BITS-1:0] shift;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (!i_rx) begin   // Start edge
                        state    <= RX_START;
                        tick_cnt <= '0;
                    end
                end
                RX_START: begin
                    if (i_tick) begin
                        if (tick_cnt == 4'd7) begin   // Middle of start bit
                            state    <= i_rx ? RX_IDLE : RX_DATA;   // Reject glitches
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + 4'd1;
                        end
                    end
                end
                RX_DATA: begin
                    if (i_tick) begin
                        if (tick_cnt == 4'd15) begin   // Mid data bit, sampled below
                            tick_cnt <= '0;
                            if (bit_cnt == bit_cnt_t'(DATA_BITS - 1))
                                state <= RX_STOP;
                            else
                                bit_cnt <= bit_cnt + 1'b1;
                        end else begin
                            tick_cnt <= tick_cnt + 4'd1;
                        end
                    end
                end
                RX_STOP: begin
                    if (i_tick) begin
                        if (tick_cnt == 4'(SB_TICK - 1)) begin   // Mid stop bit
                            state  <= RX_IDLE;
                            o_done <= 1'b1;
                        end else begin
                            tick_cnt <= tick_cnt + 4'd1;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && i_tick && tick_cnt == 4'd15)
            shift <= {i_rx, shift[DATA_BITS-1:1]};
    end

    assign o_data = shift;

    // A frame lasts far longer than one cycle
    a_done_single : assert property (@(posedge i_clk) disable iff (i_rst)
        o_done |=> !o_done);

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx
    import uart_pkg::*;
(
    input  wire                 i_clk,
    input  wire                 i_rst,
    input  wire                 i_tick,
    input  wire                 i_start,   // Load i_data and send a frame
    input  wire [DATA_BITS-1:0] i_data,
    output logic                o_tx,
    output logic                o_busy
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef logic [$clog2(DATA_BITS)-1:0] bit_cnt_t;

    tx_state_t            state;
    logic [3:0]           tick_cnt;
    bit_cnt_t             bit_cnt;
    logic [DATA_BITS-1:0] shift;   // Bit 0 is on the line during TX_DATA

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_tx     <= 1'b1;   // Line idles high
        end else begin
            case (state)
                TX_IDLE: begin
                    if (i_start) begin
                        state    <= TX_START;
                        tick_cnt <= '0;
                        o_tx     <= 1'b0;   // Start bit right away
                    end
                end
                TX_START: begin
                    if (i_tick) begin
                        if (tick_cnt == 4'd15) begin
                            state    <= TX_DATA;
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            o_tx     <= shift[0];
                        end else begin
                            tick_cnt <= tick_cnt + 4'd1;
                        end
                    end
                end
                TX_DATA: begin
                    if (i_tick) begin
                        if (tick_cnt == 4'd15) begin
                            tick_cnt <= '0;
                            if (bit_cnt == bit_cnt_t'(DATA_BITS - 1)) begin
                                state <= TX_STOP;
                                o_tx  <= 1'b1;       // Stop bit
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                                o_tx    <= shift[1];   // Next bit before the shift lands
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 4'd1;
                        end
                    end
                end
                TX_STOP: begin
                    if (i_tick) begin
                        if (tick_cnt == 4'(SB_TICK - 1))
                            state <= TX_IDLE;
                        else
                            tick_cnt <= tick_cnt + 4'd1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Payload shifter
    always_ff @(posedge i_clk) begin
        if (state == TX_IDLE && i_start)
            shift <= i_data;
        else if (state == TX_DATA && i_tick && tick_cnt == 4'd15)
            shift <= shift >> 1;
    end

    assign o_busy = (state != TX_IDLE);

    // Caller must wait for the frame in flight to finish
    a_no_start_busy : assert property (@(posedge i_clk) disable iff (i_rst)
        i_start |-> !o_busy);

endmodule

`default_nettype wire

// ==== src/byte_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_fifo
    import uart_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire                  i_wr,
    input  wire [DATA_BITS-1:0]  i_wr_data,
    input  wire                  i_rd,        // Pops the head shown on o_rd_data
    output logic [DATA_BITS-1:0] o_rd_data,
    output fifo_stat_t           o_stat
);

    typedef logic [FIFO_AW:0] cnt_t;   // One extra bit to hold FIFO_DEPTH

    logic [DATA_BITS-1:0] mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0]   wr_ptr;
    logic [FIFO_AW-1:0]   rd_ptr;
    cnt_t                 count;
    logic                 do_wr;
    logic                 do_rd;

    assign do_wr = i_wr && !o_stat.full;    // Overflow drops the byte
    assign do_rd = i_rd && !o_stat.empty;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_wr) mem[wr_ptr] <= i_wr_data;
    end

    assign o_rd_data = mem[rd_ptr];   // Fall-through head
    assign o_stat    = '{empty: (count == '0), full: (count == cnt_t'(FIFO_DEPTH))};

    a_no_underflow : assert property (@(posedge i_clk) disable iff (i_rst)
        i_rd |-> !o_stat.empty);
    a_count_bound : assert property (@(posedge i_clk) disable iff (i_rst)
        count <= cnt_t'(FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
    import uart_pkg::*;
    import alu_pkg::*;
(
    input  wire inst_word_u      i_inst,
    output logic [DATA_BITS-1:0] o_result
);

    logic [DATA_BITS-1:0] op_a;
    logic [DATA_BITS-1:0] op_b;
    logic [2:0]           shamt;   // Shifts use B modulo 8

    assign op_a  = i_inst.fields.op_a;
    assign op_b  = i_inst.fields.op_b;
    assign shamt = op_b[2:0];

    always_comb begin
        case (i_inst.fields.opcode)
            OP_ADD:  o_result = op_a + op_b;                // Wraps at 8 bits
            OP_SUB:  o_result = op_a - op_b;
            OP_AND:  o_result = op_a & op_b;
            OP_OR:   o_result = op_a | op_b;
            OP_XOR:  o_result = op_a ^ op_b;
            OP_NOR:  o_result = ~(op_a | op_b);
            OP_SRA:  o_result = $signed(op_a) >>> shamt;   // Sign fill
            OP_SRL:  o_result = op_a >> shamt;
            default: o_result = '0;                         // Unknown opcode
        endcase
    end

endmodule

`default_nettype wire

// ==== src/alu_cmd_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_cmd_seq
    import uart_pkg::*;
    import alu_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire fifo_stat_t      i_rx_stat,
    input  wire [DATA_BITS-1:0]  i_rx_data,   // Head of the receive FIFO
    input  wire fifo_stat_t      i_tx_stat,
    input  wire [DATA_BITS-1:0]  i_result,    // From the ALU, follows o_inst
    output logic                 o_rd,
    output inst_word_u           o_inst,
    output logic                 o_wr,
    output logic [DATA_BITS-1:0] o_wr_data
);

    logic [1:0]           byte_idx;    // 0 = A, 1 = B, 2 = opcode
    logic                 pending;     // Result not yet queued for transmit
    inst_word_u           shadow;      // Bytes collected so far
    inst_word_u           next_word;
    logic [DATA_BITS-1:0] in_byte;

    // Merge the byte being popped into the partial word
    always_comb begin
        in_byte = i_rx_data;
        if (byte_idx == 2'd2)   // Keep only the opcode bits
            in_byte = {{(DATA_BITS - OPCODE_BITS){1'b0}}, i_rx_data[OPCODE_BITS-1:0]};
        next_word                 = shadow;
        next_word.bytes[byte_idx] = in_byte;
        next_word.bytes[3]        = '0;   // Pad byte
    end

    assign o_rd      = !i_rx_stat.empty && !pending;   // Stall while a result waits
    assign o_wr      = pending && !i_tx_stat.full;
    assign o_wr_data = i_result;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            byte_idx <= '0;
            pending  <= 1'b0;
            o_inst   <= '0;
        end else begin
            if (o_wr) pending <= 1'b0;
            if (o_rd) begin
                if (byte_idx == 2'd2) begin   // Command complete
                    byte_idx <= '0;
                    o_inst   <= next_word;
                    pending  <= 1'b1;
                end else begin
                    byte_idx <= byte_idx + 2'd1;
                end
            end
        end
    end

    // Partial word
    always_ff @(posedge i_clk) begin
        if (o_rd) shadow <= next_word;
    end

endmodule

`default_nettype wire

// ==== src/uart_alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_alu_top
    import uart_pkg::*;
    import alu_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire                  i_rx,
    output logic                 o_tx,
    output inst_word_u           o_inst,
    output logic [DATA_BITS-1:0] o_result
);

    typedef logic [$clog2(TICK_DIV)-1:0] tick_cnt_t;

    tick_cnt_t            tick_cnt;
    logic                 tick;        // 16x baud strobe

    logic [DATA_BITS-1:0] rx_data;
    logic                 rx_done;
    logic [DATA_BITS-1:0] rx_head;
    fifo_stat_t           rx_stat;
    logic                 rx_rd;

    logic [DATA_BITS-1:0] tx_wr_data;
    logic                 tx_wr;
    logic [DATA_BITS-1:0] tx_head;
    fifo_stat_t           tx_stat;
    logic                 tx_start;    // Also pops u_tx_fifo
    logic                 tx_busy;

    // Baud tick divider
    always_ff @(posedge i_clk) begin
        if (i_rst)
            tick_cnt <= '0;
        else if (tick)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    assign tick = (tick_cnt == tick_cnt_t'(TICK_DIV - 1));

    uart_rx u_uart_rx (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_tick (tick),
        .i_rx   (i_rx),
        .o_data (rx_data),
        .o_done (rx_done)
    );

    byte_fifo u_rx_fifo (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wr      (rx_done),
        .i_wr_data (rx_data),
        .i_rd      (rx_rd),
        .o_rd_data (rx_head),
        .o_stat    (rx_stat)
    );

    alu_cmd_seq u_alu_cmd_seq (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_rx_stat (rx_stat),
        .i_rx_data (rx_head),
        .i_tx_stat (tx_stat),
        .i_result  (o_result),
        .o_rd      (rx_rd),
        .o_inst    (o_inst),
        .o_wr      (tx_wr),
        .o_wr_data (tx_wr_data)
    );

    alu u_alu (
        .i_inst   (o_inst),
        .o_result (o_result)
    );

    byte_fifo u_tx_fifo (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wr      (tx_wr),
        .i_wr_data (tx_wr_data),
        .i_rd      (tx_start),
        .o_rd_data (tx_head),
        .o_stat    (tx_stat)
    );

    // Busy rises the cycle after, so this is a single pulse
    assign tx_start = !tx_stat.empty && !tx_busy;

    uart_tx u_uart_tx (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_tick  (tick),
        .i_start (tx_start),
        .i_data  (tx_head),
        .o_tx    (o_tx),
        .o_busy  (tx_busy)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_uart_alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart_alu_top
    import uart_pkg::*;
    import alu_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int BIT_CLKS    = 16 * TICK_DIV;   // 64 clocks per serial bit
    localparam int FRAME_CLKS  = 10 * BIT_CLKS;
    localparam int N_DIRECTED  = 12;
    localparam int N_RANDOM    = 28;
    localparam int N_CMDS      = N_DIRECTED + N_RANDOM;
    localparam int CYCLE_LIMIT = N_CMDS * 4 * FRAME_CLKS + 20000;   // 4 frames per command

    localparam logic [OPCODE_BITS-1:0] OP_LIST [8] = '{
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SRA, OP_SRL
    };

    logic                 clk;
    logic                 rst;
    logic                 rx;
    logic                 tx;
    inst_word_u           inst;
    logic [DATA_BITS-1:0] result;

    logic        started;            // First start bit has been driven
    int          value_errors;
    int          other_errors;
    int          sent;               // Commands sent
    int          received;           // Frames decoded on o_tx
    int unsigned cycles;
    logic [15:0] lfsr;
    logic [7:0]  expected_q [$];     // Results still owed by the DUT

    uart_alu_top u_dut (
        .i_clk    (clk),
        .i_rst    (rst),
        .i_rx     (rx),
        .o_tx     (tx),
        .o_inst   (inst),
        .o_result (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);   // One step per bit taken
            r    = {r[6:0], lfsr[0]};
        end
        return r;
    endfunction

    // Expected ALU byte, built from the opcode rules
    function automatic logic [7:0] ref_result(input logic [7:0] a, input logic [7:0] b,
                                              input logic [5:0] op);
        logic [8:0] sum;
        logic [7:0] r;
        r = 8'h00;                    // Unknown opcode
        if (op == OP_ADD) begin
            sum = {1'b0, a} + {1'b0, b};
            r   = sum[7:0];           // Carry dropped
        end else if (op == OP_SUB) begin
            r = a + ~b + 8'd1;        // Two's complement
        end else if (op == OP_AND) begin
            r = a & b;
        end else if (op == OP_OR) begin
            r = a | b;
        end else if (op == OP_XOR) begin
            r = a ^ b;
        end else if (op == OP_NOR) begin
            r = ~a & ~b;
        end else if (op == OP_SRA) begin
            r = a;
            for (int i = 0; i < int'(b[2:0]); i++) r = {r[7], r[7:1]};
        end else if (op == OP_SRL) begin
            r = a;
            for (int i = 0; i < int'(b[2:0]); i++) r = {1'b0, r[7:1]};
        end
        return r;
    endfunction

    // 8N1 frame, caller sits on a falling edge
    task automatic send_byte(input logic [7:0] b);
        started = 1'b1;
        rx      = 1'b0;               // Start bit
        repeat (BIT_CLKS) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rx = b[i];                // LSB first
            repeat (BIT_CLKS) @(negedge clk);
        end
        rx = 1'b1;                    // Stop bit
        repeat (BIT_CLKS) @(negedge clk);
    endtask

    task automatic check_inst(input logic [31:0] exp_word, input logic [7:0] exp_res);
        assert (inst == exp_word) else begin
            value_errors++;
            $display("[ERROR] %0t o_inst: expected %08h, got %08h", $time, exp_word, inst);
        end
        assert (result == exp_res) else begin
            value_errors++;
            $display("[ERROR] %0t o_result: expected %02h, got %02h", $time, exp_res, result);
        end
    endtask

    task automatic send_cmd(input logic [7:0] a, input logic [7:0] b, input logic [7:0] op_byte);
        logic [5:0]  op;
        logic [31:0] exp_word;
        op       = op_byte[5:0];      // Top two bits ignored by the DUT
        exp_word = {8'h00, 2'b00, op, b, a};
        expected_q.push_back(ref_result(a, b, op));
        sent++;
        send_byte(a);
        send_byte(b);
        send_byte(op_byte);
        check_inst(exp_word, ref_result(a, b, op));   // Latched mid stop bit
    endtask

    task automatic wait_results();
        while (received < sent) @(negedge clk);   // Watchdog bounds this
    endtask

    task automatic send_and_wait(input logic [7:0] a, input logic [7:0] b,
                                 input logic [7:0] op_byte);
        send_cmd(a, b, op_byte);
        wait_results();
    endtask

    // Decode o_tx frames, sampled mid-bit on falling edges
    initial begin : tx_monitor
        logic [7:0] b;
        logic [7:0] exp;
        forever begin
            @(negedge clk);
            if (!rst && !tx) begin
                repeat (BIT_CLKS / 2) @(negedge clk);
                assert (!tx) else begin
                    other_errors++;
                    $display("%0t start bit on o_tx did not stay low", $time);
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CLKS) @(negedge clk);
                    b[i] = tx;
                end
                repeat (BIT_CLKS) @(negedge clk);
                assert (tx) else begin
                    other_errors++;
                    $display("%0t stop bit missing on o_tx", $time);
                end
                received++;
                if (expected_q.size() == 0) begin
                    other_errors++;
                    $display("%0t frame on o_tx with no command outstanding", $time);
                end else begin
                    exp = expected_q.pop_front();
                    assert (b == exp) else begin
                        value_errors++;
                        $display("[ERROR] %0t o_tx byte: expected %02h, got %02h", $time, exp, b);
                    end
                end
            end
        end
    end

    // Quiet outputs until the host talks
    a_tx_idle : assert property (@(posedge clk) disable iff (rst) !started |-> tx)
        else begin
            value_errors++;
            $display("[ERROR] %0t o_tx: expected 1, got %b", $time, $sampled(tx));
        end
    a_inst_zero : assert property (@(posedge clk) disable iff (rst) !started |-> inst == '0)
        else begin
            value_errors++;
            $display("[ERROR] %0t o_inst: expected 00000000, got %08h", $time, $sampled(inst));
        end
    // Pad byte and reserved opcode bits
    a_upper_zero : assert property (@(posedge clk) disable iff (rst)
        {inst.fields.pad, inst.fields.rsv} == 10'h000)
        else begin
            value_errors++;
            $display("[ERROR] %0t o_inst[31:22]: expected 000, got %03h", $time,
                     $sampled({inst.fields.pad, inst.fields.rsv}));
        end

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d of %0d results seen", cycles, received, sent);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main_seq
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] sel;
        logic [7:0] op_byte;
        rst          = 1'b1;
        rx           = 1'b1;
        started      = 1'b0;
        value_errors = 0;
        other_errors = 0;
        sent         = 0;
        received     = 0;
        lfsr         = 16'd12;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (200) @(negedge clk);   // Idle line after reset

        // One command at a time, transmitter idle each time
        send_and_wait(8'hF0, 8'h25, {2'b00, OP_ADD});   // Wraps
        send_and_wait(8'h10, 8'h20, {2'b00, OP_SUB});   // Borrow
        send_and_wait(8'hC3, 8'h5A, {2'b00, OP_AND});
        send_and_wait(8'hC3, 8'h5A, {2'b00, OP_OR});
        send_and_wait(8'hC3, 8'h5A, {2'b00, OP_XOR});
        send_and_wait(8'hC3, 8'h14, {2'b00, OP_NOR});
        send_and_wait(8'h96, 8'h0B, {2'b00, OP_SRA});   // Shift 3, sign fill
        send_and_wait(8'h96, 8'h0B, {2'b00, OP_SRL});
        send_and_wait(8'h7F, 8'h01, 8'h00);             // Not an opcode
        send_and_wait(8'h7F, 8'h01, 8'h3F);
        send_and_wait(8'h7F, 8'h01, 8'h21);
        send_and_wait(8'h3C, 8'h0F, 8'hE6);             // XOR with top bits set

        // Back to back, several commands in flight
        for (int n = 0; n < N_RANDOM; n++) begin
            a   = rand_bits(8);
            b   = rand_bits(8);
            sel = rand_bits(4);
            if (sel < 8'd8)
                op_byte = {2'b00, OP_LIST[sel[2:0]]};
            else
                op_byte = rand_bits(8);   // Any byte, mostly unknown codes
            send_cmd(a, b, op_byte);
        end
        wait_results();
        repeat (2 * FRAME_CLKS) @(negedge clk);   // Catch stray frames

        assert (received == sent && expected_q.size() == 0) else begin
            other_errors++;
            $display("[ERROR] %0t result count: expected %0d, got %0d", $time, sent, received);
        end

        $display("Checks done: %0d value errors, %0d other errors, %0d commands, %0d results",
                 value_errors, other_errors, sent, received);
        if (value_errors + other_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
src/uart_pkg.sv
src/alu_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/byte_fifo.sv
src/alu.sv
src/alu_cmd_seq.sv
src/uart_alu_top.sv
testbench/tb_uart_alu_top.sv

// ==== Makefile ====
TOP := tb_uart_alu_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module uart_alu_top

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
